//--- logic/nx_fifo.sv
// Synchronous circular-buffer FIFO with push, pop, empty and full
`default_nettype none

module nx_fifo #(
      parameter int DEPTH = 4
    , parameter int WIDTH = 32
) (
      input  logic             clk_i
    , input  logic             rst_n_i
    // Write side
    , input  logic [WIDTH-1:0] wr_data_i
    , input  logic             wr_push_i
    // Read side, head shown with no latency
    , output logic [WIDTH-1:0] rd_data_o
    , input  logic             rd_pop_i
    // Status
    , output logic             empty_o
    , output logic             full_o
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem_q [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             do_push;
    logic             do_pop;

    // Push while full and pop while empty are ignored
    assign do_push = wr_push_i && !full_o;
    assign do_pop  = rd_pop_i && !empty_o;

    assign empty_o   = (count_q == '0);
    assign full_o    = (count_q == CNT_W'(DEPTH));
    assign rd_data_o = mem_q[rd_ptr_q];

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            // Occupancy holds when both happen together
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // Storage array
    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= wr_data_i;
        end
    end

endmodule : nx_fifo

`default_nettype wire

//--- logic/nx_input_state.sv
// Input signal registers, direct and pending sequential, with commit
`default_nettype none

module nx_input_state (
      input  logic                                  clk_i
    , input  logic                                  rst_n_i
    // Update from decoder
    , input  logic [nx_pkg::NX_INPUT_IDX_WIDTH-1:0] signal_index_i
    , input  logic                                  signal_is_seq_i
    , input  logic                                  signal_state_i
    , input  logic                                  signal_valid_i
    // Sequential commit pulse
    , input  logic                                  commit_i
    , output logic [nx_pkg::NX_INPUTS-1:0]          inputs_o
);

    logic [nx_pkg::NX_INPUTS-1:0] pending_q;
    // Inputs that have received a sequential update
    logic [nx_pkg::NX_INPUTS-1:0] seq_mask_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            inputs_o   <= '0;
            pending_q  <= '0;
            seq_mask_q <= '0;
        end else begin
            // Commit first so a same-edge direct update wins
            if (commit_i) begin
                inputs_o <= (inputs_o & ~seq_mask_q) | (pending_q & seq_mask_q);
            end
            if (signal_valid_i && signal_is_seq_i) begin
                pending_q[signal_index_i]  <= signal_state_i;
                seq_mask_q[signal_index_i] <= 1'b1;
            end else if (signal_valid_i) begin
                inputs_o[signal_index_i]   <= signal_state_i;
                seq_mask_q[signal_index_i] <= 1'b0;
            end
        end
    end

endmodule : nx_input_state

`default_nettype wire

//--- logic/nx_instr_store.sv
// Instruction store filled in load order, with read port and load count
`default_nettype none

module nx_instr_store #(
      parameter int INSTR_DEPTH = 16
) (
      input  logic                                  clk_i
    , input  logic                                  rst_n_i
    // Load from decoder
    , input  logic [nx_pkg::NX_INSTR_WIDTH-1:0]     instr_data_i
    , input  logic                                  instr_valid_i
    // Read port
    , input  logic [$clog2(INSTR_DEPTH)-1:0]        rd_addr_i
    , output logic [nx_pkg::NX_INSTR_WIDTH-1:0]     rd_data_o
    , output logic [$clog2(INSTR_DEPTH+1)-1:0]      count_o
);

    localparam int AW = $clog2(INSTR_DEPTH);
    localparam int CW = $clog2(INSTR_DEPTH + 1);

    logic [nx_pkg::NX_INSTR_WIDTH-1:0] mem_q [INSTR_DEPTH];
    logic                              store_full;

    // Loads past the last slot are dropped
    assign store_full = (count_o == CW'(INSTR_DEPTH));
    assign rd_data_o  = mem_q[rd_addr_i];

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            count_o <= '0;
            for (int i = 0; i < INSTR_DEPTH; i++) begin
                mem_q[i] <= '0;
            end
        end else if (instr_valid_i && !store_full) begin
            // Next free slot is the current count
            mem_q[count_o[AW-1:0]] <= instr_data_i;
            count_o                <= count_o + 1'b1;
        end
    end

endmodule : nx_instr_store

`default_nettype wire

//--- logic/nx_msg_decoder.sv
// Message decoder: inbound FIFO, local command strobes, bypass routing
`default_nettype none

module nx_msg_decoder #(
      parameter int FIFO_DEPTH = 4
) (
      input  logic                                   clk_i
    , input  logic                                   rst_n_i
    // Own mesh address
    , input  logic [nx_pkg::NX_ROW_WIDTH-1:0]        node_row_i
    , input  logic [nx_pkg::NX_COL_WIDTH-1:0]        node_col_i
    // Inbound and bypass streams
    , nx_msg_stream_if.consumer                      msg
    , nx_msg_stream_if.producer                      bypass
    , output logic                                   idle_o
    // Output mapping update
    , output logic [nx_pkg::NX_OUTPUT_IDX_WIDTH-1:0] map_idx_o
    , output logic [nx_pkg::NX_ROW_WIDTH-1:0]        map_tgt_row_o
    , output logic [nx_pkg::NX_COL_WIDTH-1:0]        map_tgt_col_o
    , output logic [nx_pkg::NX_INPUT_IDX_WIDTH-1:0]  map_tgt_idx_o
    , output logic                                   map_tgt_seq_o
    , output logic                                   map_valid_o
    // Input signal update
    , output logic [nx_pkg::NX_INPUT_IDX_WIDTH-1:0]  signal_index_o
    , output logic                                   signal_is_seq_o
    , output logic                                   signal_state_o
    , output logic                                   signal_valid_o
    // Instruction load
    , output logic [nx_pkg::NX_INSTR_WIDTH-1:0]      instr_data_o
    , output logic                                   instr_valid_o
);

    logic                       fifo_empty;
    logic                       fifo_full;
    logic                       fifo_pop_q;
    nx_pkg::nx_message_t        head;
    logic                       decide;
    logic                       is_local;
    nx_pkg::nx_direction_t      route_dir;
    // Decision stage
    logic                       local_q;
    logic                       byp_valid_q;
    nx_pkg::nx_message_t        msg_q;
    nx_pkg::nx_direction_t      byp_dir_q;
    // Payload views of the held message
    nx_pkg::nx_msg_load_instr_t as_instr;
    nx_pkg::nx_msg_map_output_t as_map;
    nx_pkg::nx_msg_sig_state_t  as_sig;

    nx_fifo #(
          .DEPTH (FIFO_DEPTH)
        , .WIDTH (nx_pkg::NX_STREAM_WIDTH)
    ) u_fifo (
          .clk_i     (clk_i)
        , .rst_n_i   (rst_n_i)
        , .wr_data_i (msg.data)
        , .wr_push_i (msg.valid && msg.ready)
        , .rd_data_o (head)
        , .rd_pop_i  (fifo_pop_q)
        , .empty_o   (fifo_empty)
        , .full_o    (fifo_full)
    );

    assign msg.ready = !fifo_full;
    assign idle_o    = fifo_empty && !msg.valid && !byp_valid_q;

    // Head present, bypass free, and not the cycle of a pending pop
    assign decide   = !byp_valid_q && !fifo_empty && !fifo_pop_q;
    assign is_local = (head.header.row == node_row_i) && (head.header.column == node_col_i);

    // Row first, then column
    always_comb begin
        if (head.header.row < node_row_i) begin
            route_dir = nx_pkg::NX_DIRX_NORTH;
        end else if (head.header.row > node_row_i) begin
            route_dir = nx_pkg::NX_DIRX_SOUTH;
        end else if (head.header.column < node_col_i) begin
            route_dir = nx_pkg::NX_DIRX_WEST;
        end else begin
            route_dir = nx_pkg::NX_DIRX_EAST;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            fifo_pop_q     <= 1'b0;
            local_q        <= 1'b0;
            byp_valid_q    <= 1'b0;
            instr_valid_o  <= 1'b0;
            map_valid_o    <= 1'b0;
            signal_valid_o <= 1'b0;
        end else begin
            fifo_pop_q <= decide;
            local_q    <= decide && is_local;
            // One-cycle strobes, unused command falls through
            instr_valid_o  <= local_q && (msg_q.header.command == nx_pkg::NX_CMD_LOAD_INSTR);
            map_valid_o    <= local_q && (msg_q.header.command == nx_pkg::NX_CMD_MAP_OUTPUT);
            signal_valid_o <= local_q && (msg_q.header.command == nx_pkg::NX_CMD_SIG_STATE);
            // Bypass handoff, then reload on a forward decision
            if (bypass.ready) begin
                byp_valid_q <= 1'b0;
            end
            if (decide && !is_local) begin
                byp_valid_q <= 1'b1;
            end
        end
    end

    // Held until the next decision, which waits on the bypass
    always_ff @(posedge clk_i) begin
        if (decide) begin
            msg_q     <= head;
            byp_dir_q <= route_dir;
        end
    end

    assign bypass.data  = msg_q;
    assign bypass.dir   = byp_dir_q;
    assign bypass.valid = byp_valid_q;

    assign as_instr = nx_pkg::nx_msg_load_instr_t'(msg_q);
    assign as_map   = nx_pkg::nx_msg_map_output_t'(msg_q);
    assign as_sig   = nx_pkg::nx_msg_sig_state_t'(msg_q);

    assign instr_data_o    = as_instr.instruction;
    assign map_idx_o       = as_map.source_index;
    assign map_tgt_row_o   = as_map.target_row;
    assign map_tgt_col_o   = as_map.target_column;
    assign map_tgt_idx_o   = as_map.target_index;
    assign map_tgt_seq_o   = as_map.target_is_seq;
    assign signal_index_o  = as_sig.target_index;
    assign signal_is_seq_o = as_sig.target_is_seq;
    assign signal_state_o  = as_sig.state;

endmodule : nx_msg_decoder

`default_nettype wire

//--- logic/nx_msg_stream_if.sv
// Directed message stream interface with producer and consumer modports
`default_nettype none

interface nx_msg_stream_if;

    // Message word and its travel direction
    nx_pkg::nx_message_t   data;
    nx_pkg::nx_direction_t dir;
    // Handshake, transfer when both high on a clock edge
    logic                  valid;
    logic                  ready;

    modport producer (output data, output dir, output valid, input ready);

    modport consumer (input data, input dir, input valid, output ready);

endinterface : nx_msg_stream_if

`default_nettype wire

//--- logic/nx_node.sv
// Mesh node top level: decoder, instruction store, output map, input state
`default_nettype none

module nx_node #(
      parameter int FIFO_DEPTH  = 4
    , parameter int INSTR_DEPTH = 16
) (
      input  logic                                   clk_i
    , input  logic                                   rst_n_i
    , input  logic [nx_pkg::NX_ROW_WIDTH-1:0]        node_row_i
    , input  logic [nx_pkg::NX_COL_WIDTH-1:0]        node_col_i
    // Inbound stream
    , input  nx_pkg::nx_message_t                    msg_data_i
    , input  nx_pkg::nx_direction_t                  msg_dir_i
    , input  logic                                   msg_valid_i
    , output logic                                   msg_ready_o
    // Bypass stream
    , output nx_pkg::nx_message_t                    bypass_data_o
    , output nx_pkg::nx_direction_t                  bypass_dir_o
    , output logic                                   bypass_valid_o
    , input  logic                                   bypass_ready_i
    // Status and commit
    , output logic                                   idle_o
    , input  logic                                   commit_i
    // Instruction read-back
    , input  logic [$clog2(INSTR_DEPTH)-1:0]         instr_rd_addr_i
    , output logic [nx_pkg::NX_INSTR_WIDTH-1:0]      instr_rd_data_o
    , output logic [$clog2(INSTR_DEPTH+1)-1:0]       instr_count_o
    // Output map read-back
    , input  logic [nx_pkg::NX_OUTPUT_IDX_WIDTH-1:0] map_rd_idx_i
    , output logic [nx_pkg::NX_ROW_WIDTH-1:0]        map_rd_row_o
    , output logic [nx_pkg::NX_COL_WIDTH-1:0]        map_rd_col_o
    , output logic [nx_pkg::NX_INPUT_IDX_WIDTH-1:0]  map_rd_tgt_idx_o
    , output logic                                   map_rd_seq_o
    , output logic [nx_pkg::NX_INPUTS-1:0]           inputs_o
);

    logic [nx_pkg::NX_OUTPUT_IDX_WIDTH-1:0] map_idx;
    logic [nx_pkg::NX_ROW_WIDTH-1:0]        map_tgt_row;
    logic [nx_pkg::NX_COL_WIDTH-1:0]        map_tgt_col;
    logic [nx_pkg::NX_INPUT_IDX_WIDTH-1:0]  map_tgt_idx;
    logic                                   map_tgt_seq;
    logic                                   map_valid;
    logic [nx_pkg::NX_INPUT_IDX_WIDTH-1:0]  signal_index;
    logic                                   signal_is_seq;
    logic                                   signal_state;
    logic                                   signal_valid;
    logic [nx_pkg::NX_INSTR_WIDTH-1:0]      instr_data;
    logic                                   instr_valid;

    nx_msg_stream_if msg_if ();
    nx_msg_stream_if byp_if ();

    // Top ports onto the stream interfaces
    assign msg_if.data    = msg_data_i;
    assign msg_if.dir     = msg_dir_i;
    assign msg_if.valid   = msg_valid_i;
    assign msg_ready_o    = msg_if.ready;
    assign bypass_data_o  = byp_if.data;
    assign bypass_dir_o   = byp_if.dir;
    assign bypass_valid_o = byp_if.valid;
    assign byp_if.ready   = bypass_ready_i;

    nx_msg_decoder #(
          .FIFO_DEPTH (FIFO_DEPTH)
    ) u_decoder (
          .clk_i           (clk_i)
        , .rst_n_i         (rst_n_i)
        , .node_row_i      (node_row_i)
        , .node_col_i      (node_col_i)
        , .msg             (msg_if.consumer)
        , .bypass          (byp_if.producer)
        , .idle_o          (idle_o)
        , .map_idx_o       (map_idx)
        , .map_tgt_row_o   (map_tgt_row)
        , .map_tgt_col_o   (map_tgt_col)
        , .map_tgt_idx_o   (map_tgt_idx)
        , .map_tgt_seq_o   (map_tgt_seq)
        , .map_valid_o     (map_valid)
        , .signal_index_o  (signal_index)
        , .signal_is_seq_o (signal_is_seq)
        , .signal_state_o  (signal_state)
        , .signal_valid_o  (signal_valid)
        , .instr_data_o    (instr_data)
        , .instr_valid_o   (instr_valid)
    );

    nx_instr_store #(
          .INSTR_DEPTH (INSTR_DEPTH)
    ) u_instr_store (
          .clk_i         (clk_i)
        , .rst_n_i       (rst_n_i)
        , .instr_data_i  (instr_data)
        , .instr_valid_i (instr_valid)
        , .rd_addr_i     (instr_rd_addr_i)
        , .rd_data_o     (instr_rd_data_o)
        , .count_o       (instr_count_o)
    );

    nx_output_map u_output_map (
          .clk_i        (clk_i)
        , .rst_n_i      (rst_n_i)
        , .map_idx_i    (map_idx)
        , .tgt_row_i    (map_tgt_row)
        , .tgt_col_i    (map_tgt_col)
        , .tgt_idx_i    (map_tgt_idx)
        , .tgt_seq_i    (map_tgt_seq)
        , .map_valid_i  (map_valid)
        , .rd_idx_i     (map_rd_idx_i)
        , .rd_row_o     (map_rd_row_o)
        , .rd_col_o     (map_rd_col_o)
        , .rd_tgt_idx_o (map_rd_tgt_idx_o)
        , .rd_seq_o     (map_rd_seq_o)
    );

    nx_input_state u_input_state (
          .clk_i           (clk_i)
        , .rst_n_i         (rst_n_i)
        , .signal_index_i  (signal_index)
        , .signal_is_seq_i (signal_is_seq)
        , .signal_state_i  (signal_state)
        , .signal_valid_i  (signal_valid)
        , .commit_i        (commit_i)
        , .inputs_o        (inputs_o)
    );

endmodule : nx_node

`default_nettype wire

//--- logic/nx_output_map.sv
// Per-output target table with update strobe and read port
`default_nettype none

module nx_output_map (
      input  logic                                   clk_i
    , input  logic                                   rst_n_i
    // Update from decoder
    , input  logic [nx_pkg::NX_OUTPUT_IDX_WIDTH-1:0] map_idx_i
    , input  logic [nx_pkg::NX_ROW_WIDTH-1:0]        tgt_row_i
    , input  logic [nx_pkg::NX_COL_WIDTH-1:0]        tgt_col_i
    , input  logic [nx_pkg::NX_INPUT_IDX_WIDTH-1:0]  tgt_idx_i
    , input  logic                                   tgt_seq_i
    , input  logic                                   map_valid_i
    // Read port
    , input  logic [nx_pkg::NX_OUTPUT_IDX_WIDTH-1:0] rd_idx_i
    , output logic [nx_pkg::NX_ROW_WIDTH-1:0]        rd_row_o
    , output logic [nx_pkg::NX_COL_WIDTH-1:0]        rd_col_o
    , output logic [nx_pkg::NX_INPUT_IDX_WIDTH-1:0]  rd_tgt_idx_o
    , output logic                                   rd_seq_o
);

    // One entry per node output
    logic [nx_pkg::NX_ROW_WIDTH-1:0]       row_q [nx_pkg::NX_OUTPUTS];
    logic [nx_pkg::NX_COL_WIDTH-1:0]       col_q [nx_pkg::NX_OUTPUTS];
    logic [nx_pkg::NX_INPUT_IDX_WIDTH-1:0] idx_q [nx_pkg::NX_OUTPUTS];
    logic [nx_pkg::NX_OUTPUTS-1:0]         seq_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            seq_q <= '0;
            for (int i = 0; i < nx_pkg::NX_OUTPUTS; i++) begin
                row_q[i] <= '0;
                col_q[i] <= '0;
                idx_q[i] <= '0;
            end
        end else if (map_valid_i) begin
            // Later mapping simply overwrites
            row_q[map_idx_i] <= tgt_row_i;
            col_q[map_idx_i] <= tgt_col_i;
            idx_q[map_idx_i] <= tgt_idx_i;
            seq_q[map_idx_i] <= tgt_seq_i;
        end
    end

    assign rd_row_o     = row_q[rd_idx_i];
    assign rd_col_o     = col_q[rd_idx_i];
    assign rd_tgt_idx_o = idx_q[rd_idx_i];
    assign rd_seq_o     = seq_q[rd_idx_i];

endmodule : nx_output_map

`default_nettype wire

//--- logic/nx_pkg.sv
// Message field widths, command and direction enums, message layout structs
`default_nettype none

package nx_pkg;

    // Stream and address widths
    localparam int NX_STREAM_WIDTH = 32;
    localparam int NX_ROW_WIDTH    = 4;
    localparam int NX_COL_WIDTH    = 4;
    localparam int NX_CMD_WIDTH    = 2;

    // Node I/O and instruction sizes
    localparam int NX_INPUTS      = 8;
    localparam int NX_OUTPUTS     = 8;
    localparam int NX_INSTR_WIDTH = 15;

    // Derived index widths
    localparam int NX_INPUT_IDX_WIDTH  = $clog2(NX_INPUTS);
    localparam int NX_OUTPUT_IDX_WIDTH = $clog2(NX_OUTPUTS);
    localparam int NX_HEADER_WIDTH     = NX_ROW_WIDTH + NX_COL_WIDTH + NX_CMD_WIDTH;
    localparam int NX_PAYLOAD_WIDTH    = NX_STREAM_WIDTH - NX_HEADER_WIDTH;

    typedef enum logic [NX_CMD_WIDTH-1:0] {
        NX_CMD_LOAD_INSTR = 2'd0,
        NX_CMD_MAP_OUTPUT = 2'd1,
        NX_CMD_SIG_STATE  = 2'd2,
        NX_CMD_UNUSED     = 2'd3
    } nx_command_t;

    // Forwarding direction towards the target node
    typedef enum logic [1:0] {
        NX_DIRX_NORTH = 2'd0,
        NX_DIRX_EAST  = 2'd1,
        NX_DIRX_SOUTH = 2'd2,
        NX_DIRX_WEST  = 2'd3
    } nx_direction_t;

    // Common header, top 10 bits of every message
    typedef struct packed {
        logic [NX_ROW_WIDTH-1:0] row;
        logic [NX_COL_WIDTH-1:0] column;
        nx_command_t             command;
    } nx_msg_header_t;

    typedef struct packed {
        nx_msg_header_t              header;
        logic [NX_PAYLOAD_WIDTH-1:0] payload;
    } nx_message_t;

    typedef struct packed {
        nx_msg_header_t                                 header;
        logic [NX_INSTR_WIDTH-1:0]                      instruction;
        logic [NX_PAYLOAD_WIDTH-NX_INSTR_WIDTH-1:0]     padding;
    } nx_msg_load_instr_t;

    typedef struct packed {
        nx_msg_header_t                 header;
        logic [NX_OUTPUT_IDX_WIDTH-1:0] source_index;
        logic [NX_ROW_WIDTH-1:0]        target_row;
        logic [NX_COL_WIDTH-1:0]        target_column;
        logic [NX_INPUT_IDX_WIDTH-1:0]  target_index;
        logic                           target_is_seq;
        logic [6:0]                     padding;
    } nx_msg_map_output_t;

    typedef struct packed {
        nx_msg_header_t                header;
        logic [NX_INPUT_IDX_WIDTH-1:0] target_index;
        logic                          target_is_seq;
        logic                          state;
        logic [16:0]                   padding;
    } nx_msg_sig_state_t;

endpackage : nx_pkg

`default_nettype wire

//--- run.sh
#!/bin/sh
# Build the nx_node testbench with Verilator, run it, and check the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module nx_node_tb -f vlog.f -o nx_node_sim \
    && ./obj_dir/nx_node_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^Test passed$" sim.log && echo "simulation PASS" || { echo "simulation FAIL"; exit 1; }

//--- verif/nx_clk_gen.sv
// Testbench clock and synchronous reset generator
`default_nettype none

module nx_clk_gen (
      output logic clk_o
    , output logic rst_n_o
);

    timeunit 1ns;
    timeprecision 100ps;

    // 4 ns period
    initial begin
        clk_o = 1'b0;
        forever #2 clk_o = ~clk_o;
    end

    // Low for 5 rising edges, released on a falling edge
    initial begin
        rst_n_o = 1'b0;
        repeat (5) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

endmodule : nx_clk_gen

`default_nettype wire

//--- verif/nx_node_tb.sv
// Testbench for nx_node with data-file driven messages, read-back and bypass checks
`default_nettype none

module nx_node_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int FIFO_DEPTH  = 4;
    localparam int INSTR_DEPTH = 16;
    localparam int AW          = $clog2(INSTR_DEPTH);
    localparam int CW          = $clog2(INSTR_DEPTH + 1);
    localparam int REC_WORDS   = 5;
    localparam int MAX_RECS    = 64;
    localparam int TIMEOUT     = 200;

    // Record kinds in the data file
    localparam int K_SEND     = 1;
    localparam int K_FORWARD  = 2;
    localparam int K_COUNT    = 3;
    localparam int K_INSTR    = 4;
    localparam int K_MAP      = 5;
    localparam int K_INPUTS   = 6;
    localparam int K_COMMIT   = 7;
    localparam int K_BACKPRES = 8;

    logic                   clk;
    logic                   rst_n;
    logic [3:0]             node_row;
    logic [3:0]             node_col;
    logic [31:0]            msg_data;
    nx_pkg::nx_direction_t  msg_dir;
    logic                   msg_valid;
    logic                   msg_ready;
    logic [31:0]            bypass_data;
    nx_pkg::nx_direction_t  bypass_dir;
    logic                   bypass_valid;
    logic                   bypass_ready;
    logic                   idle;
    logic                   commit;
    logic [AW-1:0]          instr_rd_addr;
    logic [14:0]            instr_rd_data;
    logic [CW-1:0]          instr_count;
    logic [2:0]             map_rd_idx;
    logic [3:0]             map_rd_row;
    logic [3:0]             map_rd_col;
    logic [2:0]             map_rd_tgt_idx;
    logic                   map_rd_seq;
    logic [7:0]             inputs;

    logic [31:0] tests_mem [MAX_RECS * REC_WORDS];
    // Errors of the current test and totals over the run
    int          errors;
    int          tests_run;
    int          failed_tests;

    nx_clk_gen u_clk_gen (
          .clk_o   (clk)
        , .rst_n_o (rst_n)
    );

    nx_node #(
          .FIFO_DEPTH  (FIFO_DEPTH)
        , .INSTR_DEPTH (INSTR_DEPTH)
    ) u_nx_node (
          .clk_i            (clk)
        , .rst_n_i          (rst_n)
        , .node_row_i       (node_row)
        , .node_col_i       (node_col)
        , .msg_data_i       (msg_data)
        , .msg_dir_i        (msg_dir)
        , .msg_valid_i      (msg_valid)
        , .msg_ready_o      (msg_ready)
        , .bypass_data_o    (bypass_data)
        , .bypass_dir_o     (bypass_dir)
        , .bypass_valid_o   (bypass_valid)
        , .bypass_ready_i   (bypass_ready)
        , .idle_o           (idle)
        , .commit_i         (commit)
        , .instr_rd_addr_i  (instr_rd_addr)
        , .instr_rd_data_o  (instr_rd_data)
        , .instr_count_o    (instr_count)
        , .map_rd_idx_i     (map_rd_idx)
        , .map_rd_row_o     (map_rd_row)
        , .map_rd_col_o     (map_rd_col)
        , .map_rd_tgt_idx_o (map_rd_tgt_idx)
        , .map_rd_seq_o     (map_rd_seq)
        , .inputs_o         (inputs)
    );

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        assert (got === exp) else begin
            $display("[FAIL] %s: got 0x%08h, expected 0x%08h", name, got, exp);
            errors++;
        end
    endtask

    task automatic expect_true(input bit cond, input string what);
        assert (cond) else begin
            $display("Error: %s", what);
            errors++;
        end
    endtask

    // Starts on a falling edge and returns on the falling edge after the handshake
    task automatic send_word(input logic [31:0] word);
        int waited;
        waited    = 0;
        msg_data  = word;
        msg_valid = 1'b1;
        // Ready only moves on rising edges
        while (!msg_ready && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        expect_true(msg_ready, "msg_ready_o stayed low, message was not accepted");
        @(negedge clk);
        msg_valid = 1'b0;
    endtask

    task automatic wait_idle();
        int waited;
        waited = 0;
        while (!idle && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        expect_true(idle, "idle_o did not return high");
    endtask

    // Strobe lands one edge after the pop that makes the node idle
    task automatic drain_strobe();
        repeat (2) @(negedge clk);
    endtask

    task automatic receive_forward(input logic [31:0] word, input logic [31:0] dir);
        int waited;
        waited = 0;
        while (!bypass_valid && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        expect_true(bypass_valid, "bypass_valid_o did not rise for a forwarded message");
        compare_value("bypass_data_o", bypass_data, word);
        compare_value("bypass_dir_o", 32'(bypass_dir), dir);
        // Taken on the next rising edge
        @(negedge clk);
    endtask

    function automatic string kind_name(input int kind);
        case (kind)
            K_SEND:     return "send_local";
            K_FORWARD:  return "forward";
            K_COUNT:    return "instr_count";
            K_INSTR:    return "instr_read";
            K_MAP:      return "map_read";
            K_INPUTS:   return "inputs";
            K_COMMIT:   return "commit";
            K_BACKPRES: return "back_pressure";
            default:    return "unknown";
        endcase
    endfunction

    initial begin
        int            rec;
        int            kind;
        int            sent;
        int            waited;
        logic [31:0]   word;
        logic [31:0]   byp;
        logic [31:0]   exp_a;
        logic [31:0]   exp_b;
        logic [CW-1:0] count_before;
        logic [7:0]    inputs_before;

        node_row      = 4'd5;
        node_col      = 4'd5;
        msg_data      = '0;
        msg_dir       = nx_pkg::NX_DIRX_NORTH;
        msg_valid     = 1'b0;
        bypass_ready  = 1'b1;
        commit        = 1'b0;
        instr_rd_addr = '0;
        map_rd_idx    = '0;
        tests_run     = 0;
        failed_tests  = 0;
        errors        = 0;

        // Unused records read as kind zero, which ends the list
        for (int i = 0; i < MAX_RECS * REC_WORDS; i++) begin
            tests_mem[i] = '0;
        end
        $readmemh("verif/nx_node_tests.txt", tests_mem);

        waited = 0;
        while (!rst_n && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        expect_true(rst_n, "reset was never released");
        @(negedge clk);
        compare_value("idle_o", 32'(idle), 32'd1);
        compare_value("msg_ready_o", 32'(msg_ready), 32'd1);
        compare_value("bypass_valid_o", 32'(bypass_valid), 32'd0);
        compare_value("instr_count_o", 32'(instr_count), 32'd0);
        compare_value("inputs_o", 32'(inputs), 32'd0);
        tests_run++;
        if (errors != 0) begin
            failed_tests++;
        end
        $display("test 0 reset_state: %0d error(s)", errors);

        for (rec = 0; rec < MAX_RECS; rec++) begin
            kind  = int'(tests_mem[rec * REC_WORDS]);
            word  = tests_mem[rec * REC_WORDS + 1];
            byp   = tests_mem[rec * REC_WORDS + 2];
            exp_a = tests_mem[rec * REC_WORDS + 3];
            exp_b = tests_mem[rec * REC_WORDS + 4];
            if (kind == 0) begin
                break;
            end
            errors       = 0;
            bypass_ready = byp[0];
            case (kind)
                K_SEND: begin
                    send_word(word);
                    wait_idle();
                    drain_strobe();
                end
                K_FORWARD: begin
                    count_before  = instr_count;
                    inputs_before = inputs;
                    send_word(word);
                    receive_forward(word, exp_a);
                    wait_idle();
                    drain_strobe();
                    compare_value("instr_count_o", 32'(instr_count), 32'(count_before));
                    compare_value("inputs_o", 32'(inputs), 32'(inputs_before));
                end
                K_COUNT: begin
                    compare_value("instr_count_o", 32'(instr_count), exp_a);
                end
                K_INSTR: begin
                    instr_rd_addr = exp_a[AW-1:0];
                    @(negedge clk);
                    compare_value("instr_rd_data_o", 32'(instr_rd_data), exp_b);
                end
                K_MAP: begin
                    // Expected digits are row, column, index and seq
                    map_rd_idx = exp_a[2:0];
                    @(negedge clk);
                    compare_value("map_rd_row_o", 32'(map_rd_row), 32'(exp_b[15:12]));
                    compare_value("map_rd_col_o", 32'(map_rd_col), 32'(exp_b[11:8]));
                    compare_value("map_rd_tgt_idx_o", 32'(map_rd_tgt_idx), 32'(exp_b[6:4]));
                    compare_value("map_rd_seq_o", 32'(map_rd_seq), 32'(exp_b[0]));
                end
                K_INPUTS: begin
                    compare_value("inputs_o", 32'(inputs), exp_a);
                end
                K_COMMIT: begin
                    commit = 1'b1;
                    @(negedge clk);
                    commit = 1'b0;
                end
                K_BACKPRES: begin
                    sent = 0;
                    // FIFO fills up behind the stalled bypass
                    while (msg_ready && sent < 4 * FIFO_DEPTH) begin
                        send_word(word + 32'(sent));
                        sent++;
                    end
                    expect_true(!msg_ready, "msg_ready_o never fell with the bypass stalled");
                    expect_true(sent >= FIFO_DEPTH,
                                "msg_ready_o fell before FIFO_DEPTH messages were accepted");
                    bypass_ready = 1'b1;
                    for (int i = 0; i < sent; i++) begin
                        receive_forward(word + 32'(i), exp_a);
                    end
                    wait_idle();
                end
                default: begin
                    expect_true(1'b0, "unknown record kind in the test data");
                end
            endcase
            tests_run++;
            if (errors != 0) begin
                failed_tests++;
            end
            $display("test %0d %s: %0d error(s)", rec + 1, kind_name(kind), errors);
        end

        $display("tests run: %0d, tests with errors: %0d", tests_run, failed_tests);
        if (failed_tests == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule : nx_node_tb

`default_nettype wire

//--- verif/nx_node_tests.txt
// Columns: kind message bypass_ready exp_a exp_b (hex); node is row 5, column 5
// Kinds: 1 send, 2 forward (exp_a dir), 3 count, 4 instr (addr, data), 5 map (idx, RCIS), 6 inputs, 7 commit, 8 back-pressure
1 55091A00 1 0 0
1 553FFF80 1 0 0
1 55055E00 1 0 0
3 00000000 1 3 0
4 00000000 1 0 1234
4 00000000 1 1 7FFF
4 00000000 1 2 0ABC
1 5551BC80 1 0 0
1 55748A00 1 0 0
1 55565700 1 0 0
5 00000000 1 2 CA70
5 00000000 1 6 9120
1 559A0000 1 0 0
6 00000000 1 08 0
1 55B60000 1 0 0
6 00000000 1 08 0
7 00000000 1 0 0
6 00000000 1 48 0
// Unused command to this node, no effect
1 55C00000 1 0 0
3 00000000 1 3 0
2 25000123 1 0 0
2 19000055 1 0 0
2 91401234 1 2 0
2 53800077 1 3 0
2 5B2ABCDE 1 1 0
8 7C000000 0 2 0
6 00000000 1 48 0
3 00000000 1 3 0

//--- vlog.f
logic/nx_pkg.sv
logic/nx_msg_stream_if.sv
logic/nx_fifo.sv
logic/nx_msg_decoder.sv
logic/nx_instr_store.sv
logic/nx_output_map.sv
logic/nx_input_state.sv
logic/nx_node.sv
verif/nx_clk_gen.sv
verif/nx_node_tb.sv
